// File: compile.f
rtl/pad_cfg_pkg.sv
rtl/pad_types_pkg.sv
rtl/pad_bus_if.sv
rtl/pad_input_sync.sv
rtl/jtag_overlay_mux.sv
rtl/pad_ctrl_regs.sv
rtl/pad_overlay_top.sv
dv/pad_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build the pad overlay testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_top \
  -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// File: dv/tb_top.sv
// Top-level testbench for the pad overlay path. Drives random pad values,
// JTAG traffic and GPIO commands into the DUT. pad_checker does the comparing.

`timescale 1ns/10ps

module tb_top
  import pad_cfg_pkg::*;
  import pad_types_pkg::*;
();

  localparam int NumPads     = NumPadsDefault;
  localparam int ResetCycles = 3;
  localparam int CmdCycles   = 200;  // Core mode, random commands
  localparam int PadCycles   = 100;  // Core mode, pads only
  localparam int JtagCycles  = 150;  // Strap high
  localparam int BackCycles  = 60;   // Strap low again
  localparam int DrainCycles = 4;
  localparam int TimeoutCycles = ResetCycles + CmdCycles + PadCycles + JtagCycles +
                                 BackCycles + DrainCycles + 100;

  logic               clk;
  logic               reset_i;
  logic [NumPads-1:0] pad_in_i;
  logic [NumPads-1:0] pad_out_o;
  logic [NumPads-1:0] pad_oe_o;
  logic               jtag_tck_o;
  logic               jtag_tms_o;
  logic               jtag_tdi_o;
  logic               jtag_trst_no;
  logic               jtag_tdo_i;
  logic               cmd_valid_i;
  pad_op_e            cmd_op_i;
  logic [NumPads-1:0] cmd_data_i;
  logic               jtag_active_o;
  logic [NumPads-1:0] core_in_o;

  logic [31:0] seed;
  int          cycle_count = 0;
  int          err_count;
  int          check_count;
  int          jtag_cycles;

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One clock of random pads and TDO, plus an optional random command
  task automatic drive_cycle(input logic strap, input logic send_cmd);
    @(posedge clk);
    #1;
    seed = lcg_next(seed);
    pad_in_i = seed[31 -: NumPads];
    pad_in_i[JtagEnIdxDefault] = strap;
    seed = lcg_next(seed);
    jtag_tdo_i  = seed[31];
    cmd_valid_i = send_cmd && (seed[30:29] != 2'b00);  // About 3 in 4 cycles
    cmd_op_i    = pad_op_e'(seed[28:27]);
    seed = lcg_next(seed);
    cmd_data_i  = seed[31 -: NumPads];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////////////////////

  pad_overlay_top DUT (
    .clk           (clk),
    .reset_i       (reset_i),
    .pad_in_i      (pad_in_i),
    .pad_out_o     (pad_out_o),
    .pad_oe_o      (pad_oe_o),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_trst_no  (jtag_trst_no),
    .jtag_tdo_i    (jtag_tdo_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_data_i    (cmd_data_i),
    .jtag_active_o (jtag_active_o),
    .core_in_o     (core_in_o)
  );

  pad_checker u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .pad_in_i      (pad_in_i),
    .pad_out_i     (pad_out_o),
    .pad_oe_i      (pad_oe_o),
    .tck_i         (jtag_tck_o),
    .tms_i         (jtag_tms_o),
    .tdi_i         (jtag_tdi_o),
    .trst_n_i      (jtag_trst_no),
    .tdo_i         (jtag_tdo_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_data_i    (cmd_data_i),
    .jtag_active_i (jtag_active_o),
    .core_in_i     (core_in_o),
    .err_count_o   (err_count),
    .check_count_o (check_count),
    .jtag_cycles_o (jtag_cycles)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    reset_i     = 1'b1;
    pad_in_i    = '0;
    jtag_tdo_i  = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = OP_WRITE_OUT;
    cmd_data_i  = '0;
    seed        = 32'h98a2_a7ee;

    repeat (ResetCycles) @(posedge clk);
    #1;
    reset_i = 1'b0;

    repeat (CmdCycles) drive_cycle(1'b0, 1'b1);
    repeat (PadCycles) drive_cycle(1'b0, 1'b0);
    repeat (JtagCycles) drive_cycle(1'b1, 1'b0);  // Registers must hold here
    repeat (BackCycles) drive_cycle(1'b0, 1'b1);
    repeat (DrainCycles) @(posedge clk);
    @(negedge clk);
    #1;  // Last compare done

    $display("Checks: %0d, errors: %0d, JTAG cycles seen: %0d",
             check_count, err_count, jtag_cycles);
    if (jtag_cycles == 0) begin
      $display("JTAG mode was never seen on jtag_active_o");
    end
    if (err_count == 0 && jtag_cycles > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the test did not finish within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

endmodule : tb_top

// File: dv/pad_checker.sv
// Watches the pad overlay DUT ports, runs a cycle model of the pad path
// and compares every output on the falling clock edge.

`timescale 1ns/10ps

module pad_checker
  import pad_cfg_pkg::*;
  import pad_types_pkg::*;
#(
  parameter int NumPads = NumPadsDefault
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic [NumPads-1:0] pad_in_i,
  input  logic [NumPads-1:0] pad_out_i,
  input  logic [NumPads-1:0] pad_oe_i,
  input  logic               tck_i,
  input  logic               tms_i,
  input  logic               tdi_i,
  input  logic               trst_n_i,
  input  logic               tdo_i,
  input  logic               cmd_valid_i,
  input  pad_op_e            cmd_op_i,
  input  logic [NumPads-1:0] cmd_data_i,
  input  logic               jtag_active_i,
  input  logic [NumPads-1:0] core_in_i,
  output int                 err_count_o,
  output int                 check_count_o,
  output int                 jtag_cycles_o
);

  // Strap plus the five debug pins
  localparam logic [NumPads-1:0] OverlayPins =
    (NumPads'(1) << JtagEnIdxDefault) | (NumPads'(1) << TckIdxDefault) |
    (NumPads'(1) << TmsIdxDefault) | (NumPads'(1) << TdiIdxDefault) |
    (NumPads'(1) << TrstIdxDefault) | (NumPads'(1) << TdoIdxDefault);

  logic [NumPads-1:0] sync1_m, sync2_m;      // Synchronizer stages
  logic [NumPads-1:0] out_m, oe_m;           // GPIO registers
  logic [NumPads-1:0] pad_out_m, pad_oe_m;   // Pad output flops
  logic               model_valid = 1'b0;
  logic               jtag_m;
  int                 err_count   = 0;
  int                 check_count = 0;
  int                 jtag_cycles = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////////////////////

  // Returns {out, oe} after one command
  function automatic logic [2*NumPads-1:0] apply_cmd(input logic [NumPads-1:0] out_r,
      input logic [NumPads-1:0] oe_r, input pad_op_e op, input logic [NumPads-1:0] data);
    case (op)
      OP_WRITE_OUT: return {data, oe_r};
      OP_WRITE_OE:  return {out_r, data};
      OP_SET_OUT:   return {out_r | data, oe_r};
      default:      return {out_r & ~data, oe_r};
    endcase
  endfunction

  // Returns the next {pad_out, pad_oe}
  function automatic logic [2*NumPads-1:0] pad_drive(input logic jtag,
      input logic [NumPads-1:0] core_out, input logic [NumPads-1:0] core_oe, input logic tdo);
    logic [NumPads-1:0] out_v;
    logic [NumPads-1:0] oe_v;
    if (jtag) begin
      out_v = core_out & ~OverlayPins;
      out_v[TdoIdxDefault] = tdo;
      oe_v = '0;
      oe_v[TdoIdxDefault] = 1'b1;
    end else begin
      out_v = core_out;
      oe_v  = core_oe;
    end
    return {out_v & ConnectMaskDefault, oe_v & ConnectMaskDefault};
  endfunction

  // Pads as the core sees them after the overlay
  function automatic logic [NumPads-1:0] core_view(input logic [NumPads-1:0] synced);
    logic [NumPads-1:0] view;
    view = synced & ConnectMaskDefault;
    if (synced[JtagEnIdxDefault]) begin
      view[JtagEnIdxDefault] = TieOffDefault[JtagEnIdxDefault];
      view[TckIdxDefault]    = TieOffDefault[TckIdxDefault];
      view[TmsIdxDefault]    = TieOffDefault[TmsIdxDefault];
      view[TdiIdxDefault]    = TieOffDefault[TdiIdxDefault];
      view[TrstIdxDefault]   = TieOffDefault[TrstIdxDefault];
      view[TdoIdxDefault]    = TieOffDefault[TdoIdxDefault];
    end
    return view & ConnectMaskDefault;
  endfunction

  always @(posedge clk) begin
    if (reset_i) begin
      sync1_m     <= '0;
      sync2_m     <= '0;
      out_m       <= '0;
      oe_m        <= '0;
      pad_out_m   <= '0;
      pad_oe_m    <= '0;
      model_valid <= 1'b1;
    end else begin
      {pad_out_m, pad_oe_m} <= pad_drive(sync2_m[JtagEnIdxDefault], out_m, oe_m, tdo_i);
      if (cmd_valid_i) begin
        {out_m, oe_m} <= apply_cmd(out_m, oe_m, cmd_op_i, cmd_data_i);
      end
      sync1_m <= pad_in_i & ConnectMaskDefault;
      sync2_m <= sync1_m;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_vec(input string what, input logic [NumPads-1:0] got,
      input logic [NumPads-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  always @(negedge clk) begin
    if (model_valid) begin
      jtag_m = sync2_m[JtagEnIdxDefault];
      check_vec("pad_out_o", pad_out_i, pad_out_m);
      check_vec("pad_oe_o", pad_oe_i, pad_oe_m);
      check_vec("core_in_o", core_in_i, core_view(sync2_m));
      check_bit("jtag_active_o", jtag_active_i, jtag_m);
      check_bit("jtag_tck_o", tck_i,
                jtag_m ? sync2_m[TckIdxDefault] : TieOffDefault[TckIdxDefault]);
      check_bit("jtag_tms_o", tms_i,
                jtag_m ? sync2_m[TmsIdxDefault] : TieOffDefault[TmsIdxDefault]);
      check_bit("jtag_tdi_o", tdi_i,
                jtag_m ? sync2_m[TdiIdxDefault] : TieOffDefault[TdiIdxDefault]);
      check_bit("jtag_trst_no", trst_n_i, jtag_m ? sync2_m[TrstIdxDefault] : 1'b1);
      // Missing pads stay quiet in both directions
      check_vec("unconnected pad activity",
                (pad_out_i | pad_oe_i | core_in_i) & ~ConnectMaskDefault, '0);
      if (jtag_active_i === 1'b1) begin
        jtag_cycles++;
      end
    end
  end

  assign err_count_o   = err_count;
  assign check_count_o = check_count;
  assign jtag_cycles_o = jtag_cycles;

endmodule : pad_checker

// File: rtl/pad_overlay_top.sv
// Top level of the pad path: input sync, JTAG overlay mux and GPIO control
// registers in a three-stage chain. All ports are plain vectors.

`timescale 1ns/10ps

module pad_overlay_top
  import pad_cfg_pkg::*;
  import pad_types_pkg::*;
#(
  parameter int                 NumPads     = NumPadsDefault,
  parameter int                 JtagEnIdx   = JtagEnIdxDefault,
  parameter int                 TckIdx      = TckIdxDefault,
  parameter int                 TmsIdx      = TmsIdxDefault,
  parameter int                 TdiIdx      = TdiIdxDefault,
  parameter int                 TrstIdx     = TrstIdxDefault,
  parameter int                 TdoIdx      = TdoIdxDefault,
  parameter logic [NumPads-1:0] ConnectMask = ConnectMaskDefault,
  parameter logic [NumPads-1:0] TieOff      = TieOffDefault
) (
  input  logic               clk,
  input  logic               reset_i,
  // Pads
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  // Debug port
  output logic               jtag_tck_o,
  output logic               jtag_tms_o,
  output logic               jtag_tdi_o,
  output logic               jtag_trst_no,
  input  logic               jtag_tdo_i,
  // GPIO commands
  input  logic               cmd_valid_i,
  input  pad_op_e            cmd_op_i,
  input  logic [NumPads-1:0] cmd_data_i,
  // Status
  output logic               jtag_active_o,
  output logic [NumPads-1:0] core_in_o
);

  logic [NumPads-1:0] synced;

  pad_bus_if #(.NumPads(NumPads)) core_bus ();

  pad_input_sync #(
    .NumPads     (NumPads),
    .ConnectMask (ConnectMask)
  ) u_sync (
    .clk      (clk),
    .reset_i  (reset_i),
    .pad_in_i (pad_in_i),
    .synced_o (synced)
  );

  jtag_overlay_mux #(
    .NumPads     (NumPads),
    .JtagEnIdx   (JtagEnIdx),
    .TckIdx      (TckIdx),
    .TmsIdx      (TmsIdx),
    .TdiIdx      (TdiIdx),
    .TrstIdx     (TrstIdx),
    .TdoIdx      (TdoIdx),
    .TieOff      (TieOff),
    .ConnectMask (ConnectMask)
  ) u_mux (
    .clk          (clk),
    .reset_i      (reset_i),
    .synced_i     (synced),
    .bus          (core_bus.mux_side),
    .jtag_tck_o   (jtag_tck_o),
    .jtag_tms_o   (jtag_tms_o),
    .jtag_tdi_o   (jtag_tdi_o),
    .jtag_trst_no (jtag_trst_no),
    .jtag_tdo_i   (jtag_tdo_i),
    .pad_out_o    (pad_out_o),
    .pad_oe_o     (pad_oe_o)
  );

  pad_ctrl_regs #(
    .NumPads (NumPads)
  ) u_regs (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .bus         (core_bus.core_side)
  );

  assign core_in_o     = core_bus.core_in;      // What the core would sample
  assign jtag_active_o = core_bus.jtag_active;

endmodule : pad_overlay_top

// File: rtl/pad_ctrl_regs.sv
// Stand-in for the core's GPIO registers. Holds the out and oe values that
// the overlay mux sends to the pads, updated by opcode commands.

`timescale 1ns/10ps

module pad_ctrl_regs
  import pad_cfg_pkg::*;
  import pad_types_pkg::*;
#(
  parameter int NumPads = NumPadsDefault
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               cmd_valid_i,  // Applied on every cycle it is high
  input  pad_op_e            cmd_op_i,
  input  logic [NumPads-1:0] cmd_data_i,
  pad_bus_if.core_side       bus
);

  logic [NumPads-1:0] out_q;
  logic [NumPads-1:0] oe_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (cmd_valid_i) begin
      case (cmd_op_i)
        OP_WRITE_OUT: out_q <= cmd_data_i;
        OP_WRITE_OE:  oe_q  <= cmd_data_i;
        OP_SET_OUT:   out_q <= out_q | cmd_data_i;
        OP_CLEAR_OUT: out_q <= out_q & ~cmd_data_i;
        default: begin
          out_q <= out_q;
          oe_q  <= oe_q;
        end
      endcase
    end
  end

  // Registers keep their values across JTAG sessions; the mux decides
  // whether they reach the pads
  assign bus.core_out = out_q;
  assign bus.core_oe  = oe_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_op_known : assert property (
    @(posedge clk) disable iff (reset_i)
      cmd_valid_i |-> !$isunknown(cmd_op_i)
  ) else $error("Command strobe with unknown opcode");

endmodule : pad_ctrl_regs

// File: rtl/jtag_overlay_mux.sv
// JTAG overlay between the synchronized pads and the core. While the strap
// pad is high the debug pins go to the JTAG port, the core sees tie-offs
// and only the TDO pad is driven.

`timescale 1ns/10ps

module jtag_overlay_mux
  import pad_cfg_pkg::*;
  import pad_types_pkg::*;
#(
  parameter int                 NumPads     = NumPadsDefault,
  parameter int                 JtagEnIdx   = JtagEnIdxDefault,
  parameter int                 TckIdx      = TckIdxDefault,
  parameter int                 TmsIdx      = TmsIdxDefault,
  parameter int                 TdiIdx      = TdiIdxDefault,
  parameter int                 TrstIdx     = TrstIdxDefault,
  parameter int                 TdoIdx      = TdoIdxDefault,
  parameter logic [NumPads-1:0] TieOff      = TieOffDefault,
  parameter logic [NumPads-1:0] ConnectMask = ConnectMaskDefault
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic [NumPads-1:0] synced_i,
  pad_bus_if.mux_side        bus,
  // Debug port
  output logic               jtag_tck_o,
  output logic               jtag_tms_o,
  output logic               jtag_tdi_o,
  output logic               jtag_trst_no,
  input  logic               jtag_tdo_i,
  // Pad side
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o
);

  localparam logic [NumPads-1:0] TdoMask = NumPads'(1) << TdoIdx;

  // Every pin the overlay takes away from the core, strap included
  localparam logic [NumPads-1:0] OverlayMask = (NumPads'(1) << JtagEnIdx) |
                                               (NumPads'(1) << TckIdx)    |
                                               (NumPads'(1) << TmsIdx)    |
                                               (NumPads'(1) << TdiIdx)    |
                                               (NumPads'(1) << TrstIdx)   |
                                               TdoMask;

  localparam logic TrstInactive = 1'b1;  // TRST is active low

  overlay_mode_e      mode;
  logic [NumPads-1:0] pad_out_d, pad_out_q;
  logic [NumPads-1:0] pad_oe_d, pad_oe_q;

  ////////////////////////////////////////////////////////////////////////////
  // Mode decode and input routing
  ////////////////////////////////////////////////////////////////////////////

  assign mode = synced_i[JtagEnIdx] ? MODE_JTAG : MODE_CORE;

  assign bus.jtag_active = (mode == MODE_JTAG);

  always_comb begin
    if (mode == MODE_JTAG) begin
      jtag_tck_o   = synced_i[TckIdx];
      jtag_tms_o   = synced_i[TmsIdx];
      jtag_tdi_o   = synced_i[TdiIdx];
      jtag_trst_no = synced_i[TrstIdx];
      // Core gets fixed values on the pins it lost
      bus.core_in  = ((synced_i & ~OverlayMask) | (TieOff & OverlayMask)) & ConnectMask;
    end else begin
      // Idle debug port, TAP held out of reset
      jtag_tck_o   = TieOff[TckIdx];
      jtag_tms_o   = TieOff[TmsIdx];
      jtag_tdi_o   = TieOff[TdiIdx];
      jtag_trst_no = TrstInactive;
      bus.core_in  = synced_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pad output registers
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (mode == MODE_JTAG) begin
      pad_out_d = (bus.core_out & ~OverlayMask) | (jtag_tdo_i ? TdoMask : '0);
      pad_oe_d  = TdoMask;  // TDO is the only driven pad
    end else begin
      pad_out_d = bus.core_out;
      pad_oe_d  = bus.core_oe;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pad_out_q <= '0;
      pad_oe_q  <= '0;
    end else begin
      pad_out_q <= pad_out_d & ConnectMask;  // Never drive a missing pad
      pad_oe_q  <= pad_oe_d & ConnectMask;
    end
  end

  assign pad_out_o = pad_out_q;
  assign pad_oe_o  = pad_oe_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // One cycle after JTAG owns the pins, nothing but TDO may be enabled
  a_jtag_oe_tdo_only : assert property (
    @(posedge clk) disable iff (reset_i)
      (mode == MODE_JTAG) |=> ((pad_oe_o & ~TdoMask) == '0)
  ) else $error("Pad enabled besides TDO in JTAG mode: %h", pad_oe_o);

  a_oe_connected : assert property (
    @(posedge clk) disable iff (reset_i)
      (pad_oe_o & ~ConnectMask) == '0
  ) else $error("Output enable on unconnected pad: %h", pad_oe_o);

endmodule : jtag_overlay_mux

// File: rtl/pad_input_sync.sv
// Input stage of the pad path. Brings each pad into the clk domain through
// two flops and forces unconnected pads to read 0.

`timescale 1ns/10ps

module pad_input_sync
  import pad_cfg_pkg::*;
#(
  parameter int                 NumPads     = NumPadsDefault,
  parameter logic [NumPads-1:0] ConnectMask = ConnectMaskDefault
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] synced_o
);

  logic [NumPads-1:0] sync1_q;  // First stage, may go metastable
  logic [NumPads-1:0] sync2_q;

  ////////////////////////////////////////////////////////////////////////////
  // Two-flop synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // Unconnected pads float on the board, so mask them before the first flop
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_in_i & ConnectMask;
      sync2_q <= sync1_q;
    end
  end

  assign synced_o = sync2_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Nothing downstream may ever see an unconnected pad high
  a_unconnected_low : assert property (
    @(posedge clk) disable iff (reset_i)
      (synced_o & ~ConnectMask) == '0
  ) else $error("Unconnected pad seen high after sync: %h", synced_o);

endmodule : pad_input_sync

// File: rtl/pad_bus_if.sv
// Core-side view of the pads, passed between the overlay mux and the
// GPIO control registers.

`timescale 1ns/10ps

interface pad_bus_if
  import pad_cfg_pkg::*;
#(
  parameter int NumPads = NumPadsDefault
) ();

  logic [NumPads-1:0] core_in;      // Pad values as the core sees them
  logic [NumPads-1:0] core_out;
  logic [NumPads-1:0] core_oe;
  logic               jtag_active;  // Overlay pins taken by JTAG

  modport mux_side (
    output core_in,
    output jtag_active,
    input  core_out,
    input  core_oe
  );

  modport core_side (
    input  core_in,
    input  jtag_active,
    output core_out,
    output core_oe
  );

endinterface : pad_bus_if

// File: rtl/pad_types_pkg.sv
// Enumerated types shared by the pad pipeline stages and the testbench

package pad_types_pkg;

  // Who owns the overlay pins
  typedef enum logic {
    MODE_CORE = 1'b0,
    MODE_JTAG = 1'b1
  } overlay_mode_e;

  // Command opcodes for the GPIO control registers
  typedef enum logic [1:0] {
    OP_WRITE_OUT = 2'd0,  // out <= data
    OP_WRITE_OE  = 2'd1,  // oe <= data
    OP_SET_OUT   = 2'd2,  // out <= out | data
    OP_CLEAR_OUT = 2'd3   // out <= out & ~data
  } pad_op_e;

endpackage : pad_types_pkg

// File: rtl/pad_cfg_pkg.sv
// Board-level pad configuration for the FPGA I/O wrapper.
// The top level takes its parameter defaults from here.

package pad_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad count and debug pin map
  ////////////////////////////////////////////////////////////////////////////

  parameter int NumPadsDefault = 16;

  parameter int JtagEnIdxDefault = 12;  // Strap, high selects JTAG
  parameter int TckIdxDefault    = 8;
  parameter int TmsIdxDefault    = 9;
  parameter int TdiIdxDefault    = 10;
  parameter int TrstIdxDefault   = 11;
  parameter int TdoIdxDefault    = 13;  // Only pad driven in JTAG mode

  ////////////////////////////////////////////////////////////////////////////
  // Masks
  ////////////////////////////////////////////////////////////////////////////

  // Pads 14 and 15 have no board connection
  parameter logic [NumPadsDefault-1:0] ConnectMaskDefault = 16'h3FFF;

  // Core view of the overlay pins while JTAG owns them.
  // Bit 9 doubles as an active-low select on the core side, so hold it high
  parameter logic [NumPadsDefault-1:0] TieOffDefault = 16'h0200;

endpackage : pad_cfg_pkg
